// File: Makefile
# Verilator run of the completion stage testbench

TOP := completion_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: build.f
rtl/core_pkg.sv
rtl/cdb.sv
rtl/map_table.sv
rtl/tag_status.sv
rtl/branch_redirect.sv
rtl/completion_top.sv
verification/completion_chk.sv
verification/completion_tb.sv

// File: rtl/branch_redirect.sv
`timescale 1ns/100ps
`default_nettype none

module branch_redirect (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 lane_valid0,
  input  wire logic                 lane_valid1,
  input  wire core_pkg::addr_t      br_pc0,
  input  wire core_pkg::addr_t      br_pc1,
  input  wire core_pkg::addr_t      br_actual_addr0,
  input  wire core_pkg::addr_t      br_actual_addr1,
  input  wire logic                 br_actual_taken0,
  input  wire logic                 br_actual_taken1,
  input  wire logic                 br_cond_branch0,
  input  wire logic                 br_cond_branch1,
  input  wire logic                 br_uncond_branch0,
  input  wire logic                 br_uncond_branch1,
  output logic                      redirect_valid,
  output core_pkg::addr_t           redirect_pc,
  output core_pkg::addr_t           redirect_target
);

  logic mispredict0;
  logic mispredict1;

  // front end always predicts not taken
  assign mispredict0 = lane_valid0 &&
                       ((br_cond_branch0 && br_actual_taken0) || br_uncond_branch0);
  assign mispredict1 = lane_valid1 &&
                       ((br_cond_branch1 && br_actual_taken1) || br_uncond_branch1);

  always_ff @(posedge clock)
  begin
    if (reset)
      redirect_valid <= 1'b0;
    else
      redirect_valid <= mispredict0 || mispredict1;
  end

  // ----------------------------------------------------------------------
  // redirect payload, lane 0 is older and wins
  // ----------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (mispredict0)
    begin
      redirect_pc     <= br_pc0;
      redirect_target <= br_actual_addr0;
    end
    else if (mispredict1)
    begin
      redirect_pc     <= br_pc1;
      redirect_target <= br_actual_addr1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cdb.sv
`timescale 1ns/100ps
`default_nettype none

module cdb (
  input  wire logic                 clock,
  input  wire logic                 reset,
  // simple alu lanes
  input  wire logic                 sim_complete0,
  input  wire core_pkg::preg_t      sim_pr_idx0,
  input  wire core_pkg::areg_t      sim_ar_idx0,
  input  wire logic                 sim_exception0,
  input  wire core_pkg::addr_t      sim_pc0,
  input  wire core_pkg::addr_t      sim_actual_addr0,
  input  wire logic                 sim_actual_taken0,
  input  wire logic                 sim_cond_branch0,
  input  wire logic                 sim_uncond_branch0,
  input  wire logic                 sim_complete1,
  input  wire core_pkg::preg_t      sim_pr_idx1,
  input  wire core_pkg::areg_t      sim_ar_idx1,
  input  wire logic                 sim_exception1,
  input  wire core_pkg::addr_t      sim_pc1,
  input  wire core_pkg::addr_t      sim_actual_addr1,
  input  wire logic                 sim_actual_taken1,
  input  wire logic                 sim_cond_branch1,
  input  wire logic                 sim_uncond_branch1,
  // multiplier lanes
  input  wire logic                 mul_complete0,
  input  wire core_pkg::preg_t      mul_pr_idx0,
  input  wire core_pkg::areg_t      mul_ar_idx0,
  input  wire logic                 mul_complete1,
  input  wire core_pkg::preg_t      mul_pr_idx1,
  input  wire core_pkg::areg_t      mul_ar_idx1,
  // memory lanes
  input  wire logic                 mem_complete0,
  input  wire core_pkg::preg_t      mem_pr_idx0,
  input  wire core_pkg::areg_t      mem_ar_idx0,
  input  wire logic                 mem_exception0,
  input  wire logic                 mem_complete1,
  input  wire core_pkg::preg_t      mem_pr_idx1,
  input  wire core_pkg::areg_t      mem_ar_idx1,
  input  wire logic                 mem_exception1,
  // broadcast
  output core_pkg::lane_mask_t      broadcast,
  output core_pkg::preg_t           pr_tag0,
  output core_pkg::preg_t           pr_tag1,
  output core_pkg::preg_t           pr_tag2,
  output core_pkg::preg_t           pr_tag3,
  output core_pkg::preg_t           pr_tag4,
  output core_pkg::preg_t           pr_tag5,
  output core_pkg::areg_t           ar_tag0,
  output core_pkg::areg_t           ar_tag1,
  output core_pkg::areg_t           ar_tag2,
  output core_pkg::areg_t           ar_tag3,
  output core_pkg::areg_t           ar_tag4,
  output core_pkg::areg_t           ar_tag5,
  output logic                      exception0,
  output logic                      exception1,
  output logic                      exception2,
  output logic                      exception3,
  output logic                      exception4,
  output logic                      exception5,
  output core_pkg::addr_t           br_pc0,
  output core_pkg::addr_t           br_actual_addr0,
  output logic                      br_actual_taken0,
  output logic                      br_cond_branch0,
  output logic                      br_uncond_branch0,
  output core_pkg::addr_t           br_pc1,
  output core_pkg::addr_t           br_actual_addr1,
  output logic                      br_actual_taken1,
  output logic                      br_cond_branch1,
  output logic                      br_uncond_branch1
);

  // ----------------------------------------------------------------------
  // single register stage, all six lanes every cycle
  // ----------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      broadcast         <= '0;
      pr_tag0           <= '0;
      pr_tag1           <= '0;
      pr_tag2           <= '0;
      pr_tag3           <= '0;
      pr_tag4           <= '0;
      pr_tag5           <= '0;
      ar_tag0           <= '0;
      ar_tag1           <= '0;
      ar_tag2           <= '0;
      ar_tag3           <= '0;
      ar_tag4           <= '0;
      ar_tag5           <= '0;
      exception0        <= 1'b0;
      exception1        <= 1'b0;
      exception2        <= 1'b0;
      exception3        <= 1'b0;
      exception4        <= 1'b0;
      exception5        <= 1'b0;
      br_pc0            <= '0;
      br_actual_addr0   <= '0;
      br_actual_taken0  <= 1'b0;
      br_cond_branch0   <= 1'b0;
      br_uncond_branch0 <= 1'b0;
      br_pc1            <= '0;
      br_actual_addr1   <= '0;
      br_actual_taken1  <= 1'b0;
      br_cond_branch1   <= 1'b0;
      br_uncond_branch1 <= 1'b0;
    end
    else
    begin
      broadcast <= {mem_complete1, mem_complete0,
                    mul_complete1, mul_complete0,
                    sim_complete1, sim_complete0};   // lane 0 in bit 0
      pr_tag0           <= sim_pr_idx0;
      pr_tag1           <= sim_pr_idx1;
      pr_tag2           <= mul_pr_idx0;
      pr_tag3           <= mul_pr_idx1;
      pr_tag4           <= mem_pr_idx0;
      pr_tag5           <= mem_pr_idx1;
      ar_tag0           <= sim_ar_idx0;
      ar_tag1           <= sim_ar_idx1;
      ar_tag2           <= mul_ar_idx0;
      ar_tag3           <= mul_ar_idx1;
      ar_tag4           <= mem_ar_idx0;
      ar_tag5           <= mem_ar_idx1;
      exception0        <= sim_exception0;
      exception1        <= sim_exception1;
      exception2        <= 1'b0;                 // multipliers cannot fault
      exception3        <= 1'b0;
      exception4        <= mem_exception0;
      exception5        <= mem_exception1;
      br_pc0            <= sim_pc0;
      br_actual_addr0   <= sim_actual_addr0;
      br_actual_taken0  <= sim_actual_taken0;
      br_cond_branch0   <= sim_cond_branch0;
      br_uncond_branch0 <= sim_uncond_branch0;
      br_pc1            <= sim_pc1;
      br_actual_addr1   <= sim_actual_addr1;
      br_actual_taken1  <= sim_actual_taken1;
      br_cond_branch1   <= sim_cond_branch1;
      br_uncond_branch1 <= sim_uncond_branch1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/completion_top.sv
`timescale 1ns/100ps
`default_nettype none

module completion_top (
  input  wire logic                 clock,
  input  wire logic                 reset,
  // simple alu lanes
  input  wire logic                 sim_complete0,
  input  wire core_pkg::preg_t      sim_pr_idx0,
  input  wire core_pkg::areg_t      sim_ar_idx0,
  input  wire logic                 sim_exception0,
  input  wire core_pkg::addr_t      sim_pc0,
  input  wire core_pkg::addr_t      sim_actual_addr0,
  input  wire logic                 sim_actual_taken0,
  input  wire logic                 sim_cond_branch0,
  input  wire logic                 sim_uncond_branch0,
  input  wire logic                 sim_complete1,
  input  wire core_pkg::preg_t      sim_pr_idx1,
  input  wire core_pkg::areg_t      sim_ar_idx1,
  input  wire logic                 sim_exception1,
  input  wire core_pkg::addr_t      sim_pc1,
  input  wire core_pkg::addr_t      sim_actual_addr1,
  input  wire logic                 sim_actual_taken1,
  input  wire logic                 sim_cond_branch1,
  input  wire logic                 sim_uncond_branch1,
  // multiplier lanes
  input  wire logic                 mul_complete0,
  input  wire core_pkg::preg_t      mul_pr_idx0,
  input  wire core_pkg::areg_t      mul_ar_idx0,
  input  wire logic                 mul_complete1,
  input  wire core_pkg::preg_t      mul_pr_idx1,
  input  wire core_pkg::areg_t      mul_ar_idx1,
  // memory lanes
  input  wire logic                 mem_complete0,
  input  wire core_pkg::preg_t      mem_pr_idx0,
  input  wire core_pkg::areg_t      mem_ar_idx0,
  input  wire logic                 mem_exception0,
  input  wire logic                 mem_complete1,
  input  wire core_pkg::preg_t      mem_pr_idx1,
  input  wire core_pkg::areg_t      mem_ar_idx1,
  input  wire logic                 mem_exception1,
  // rename side
  input  wire logic                 rename_valid,
  input  wire core_pkg::areg_t      rename_ar,
  input  wire core_pkg::preg_t      rename_pr,
  input  wire core_pkg::areg_t      lookup_ar,
  input  wire core_pkg::preg_t      query_tag,
  output wire core_pkg::preg_t      lookup_pr,
  output wire logic                 lookup_ready,
  output wire logic                 query_done,
  output wire logic                 query_exception,
  output wire logic                 redirect_valid,
  output wire core_pkg::addr_t      redirect_pc,
  output wire core_pkg::addr_t      redirect_target
);

  // ----------------------------------------------------------------------
  // broadcast nets
  // ----------------------------------------------------------------------
  core_pkg::lane_mask_t broadcast;
  core_pkg::preg_t      pr_tag0, pr_tag1, pr_tag2, pr_tag3, pr_tag4, pr_tag5;
  core_pkg::areg_t      ar_tag0, ar_tag1, ar_tag2, ar_tag3, ar_tag4, ar_tag5;
  logic                 exception0, exception1, exception2;
  logic                 exception3, exception4, exception5;
  core_pkg::addr_t      br_pc0, br_pc1;
  core_pkg::addr_t      br_actual_addr0, br_actual_addr1;
  logic                 br_actual_taken0, br_actual_taken1;
  logic                 br_cond_branch0, br_cond_branch1;
  logic                 br_uncond_branch0, br_uncond_branch1;

  // port names line up with the lane inputs and broadcast nets
  cdb u_cdb (
    .*
  );

  map_table u_map_table (
    .*
  );

  tag_status u_tag_status (
    .alloc_valid (rename_valid),   // rename allocates its new tag
    .alloc_tag   (rename_pr),
    .*
  );

  branch_redirect u_branch_redirect (
    .lane_valid0 (broadcast[0]),   // only the simple alu lanes branch
    .lane_valid1 (broadcast[1]),
    .*
  );

endmodule

`default_nettype wire

// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

  // ----------------------------------------------------------------------
  // widths shared by the completion stage
  // ----------------------------------------------------------------------
  localparam int preg_w    = 7;   // 128 physical registers
  localparam int areg_w    = 5;   // 32 architectural registers
  localparam int addr_w    = 64;
  localparam int num_lanes = 6;

  // lane order used everywhere:
  //   0,1 simple alu   2,3 multiplier   4,5 memory

  typedef logic [preg_w-1:0]    preg_t;
  typedef logic [areg_w-1:0]    areg_t;
  typedef logic [addr_w-1:0]    addr_t;
  typedef logic [num_lanes-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: rtl/map_table.sv
`timescale 1ns/100ps
`default_nettype none

module map_table (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 rename_valid,
  input  wire core_pkg::areg_t      rename_ar,
  input  wire core_pkg::preg_t      rename_pr,
  input  wire core_pkg::areg_t      lookup_ar,
  input  wire core_pkg::lane_mask_t broadcast,
  input  wire core_pkg::preg_t      pr_tag0,
  input  wire core_pkg::preg_t      pr_tag1,
  input  wire core_pkg::preg_t      pr_tag2,
  input  wire core_pkg::preg_t      pr_tag3,
  input  wire core_pkg::preg_t      pr_tag4,
  input  wire core_pkg::preg_t      pr_tag5,
  input  wire core_pkg::areg_t      ar_tag0,
  input  wire core_pkg::areg_t      ar_tag1,
  input  wire core_pkg::areg_t      ar_tag2,
  input  wire core_pkg::areg_t      ar_tag3,
  input  wire core_pkg::areg_t      ar_tag4,
  input  wire core_pkg::areg_t      ar_tag5,
  output core_pkg::preg_t           lookup_pr,
  output logic                      lookup_ready
);

  localparam int num_regs = 2 ** core_pkg::areg_w;

  core_pkg::preg_t     map_q [num_regs];
  logic [num_regs-1:0] ready_q;
  core_pkg::preg_t     lane_pr [core_pkg::num_lanes];
  core_pkg::areg_t     lane_ar [core_pkg::num_lanes];

  assign lane_pr[0] = pr_tag0;
  assign lane_pr[1] = pr_tag1;
  assign lane_pr[2] = pr_tag2;
  assign lane_pr[3] = pr_tag3;
  assign lane_pr[4] = pr_tag4;
  assign lane_pr[5] = pr_tag5;
  assign lane_ar[0] = ar_tag0;
  assign lane_ar[1] = ar_tag1;
  assign lane_ar[2] = ar_tag2;
  assign lane_ar[3] = ar_tag3;
  assign lane_ar[4] = ar_tag4;
  assign lane_ar[5] = ar_tag5;

  // ----------------------------------------------------------------------
  // mapping and ready update
  // ----------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        map_q[i]   <= core_pkg::preg_t'(i);   // identity mapping
        ready_q[i] <= 1'b1;
      end
    end
    else
    begin
      for (int k = 0; k < core_pkg::num_lanes; k++)
      begin
        if (broadcast[k] && (map_q[lane_ar[k]] == lane_pr[k]))
          ready_q[lane_ar[k]] <= 1'b1;        // stale tags fall through
      end
      if (rename_valid)
      begin
        map_q[rename_ar]   <= rename_pr;
        ready_q[rename_ar] <= 1'b0;           // last write, beats broadcast
      end
    end
  end

  assign lookup_pr    = map_q[lookup_ar];
  assign lookup_ready = ready_q[lookup_ar];

endmodule

`default_nettype wire

// File: rtl/tag_status.sv
`timescale 1ns/100ps
`default_nettype none

module tag_status (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 alloc_valid,
  input  wire core_pkg::preg_t      alloc_tag,
  input  wire core_pkg::lane_mask_t broadcast,
  input  wire core_pkg::preg_t      pr_tag0,
  input  wire core_pkg::preg_t      pr_tag1,
  input  wire core_pkg::preg_t      pr_tag2,
  input  wire core_pkg::preg_t      pr_tag3,
  input  wire core_pkg::preg_t      pr_tag4,
  input  wire core_pkg::preg_t      pr_tag5,
  input  wire logic                 exception0,
  input  wire logic                 exception1,
  input  wire logic                 exception2,
  input  wire logic                 exception3,
  input  wire logic                 exception4,
  input  wire logic                 exception5,
  input  wire core_pkg::preg_t      query_tag,
  output logic                      query_done,
  output logic                      query_exception
);

  localparam int num_tags = 2 ** core_pkg::preg_w;

  logic [num_tags-1:0]            done_q;
  logic [num_tags-1:0]            exc_q;
  core_pkg::preg_t                lane_pr [core_pkg::num_lanes];
  logic [core_pkg::num_lanes-1:0] lane_exc;

  assign lane_pr[0] = pr_tag0;
  assign lane_pr[1] = pr_tag1;
  assign lane_pr[2] = pr_tag2;
  assign lane_pr[3] = pr_tag3;
  assign lane_pr[4] = pr_tag4;
  assign lane_pr[5] = pr_tag5;
  assign lane_exc   = {exception5, exception4, exception3,
                       exception2, exception1, exception0};

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      done_q <= '1;   // every tag starts completed
      exc_q  <= '0;
    end
    else
    begin
      for (int k = 0; k < core_pkg::num_lanes; k++)
      begin
        if (broadcast[k])
        begin
          done_q[lane_pr[k]] <= 1'b1;
          exc_q[lane_pr[k]]  <= lane_exc[k];
        end
      end
      if (alloc_valid)
      begin
        done_q[alloc_tag] <= 1'b0;   // allocation wins
        exc_q[alloc_tag]  <= 1'b0;
      end
    end
  end

  assign query_done      = done_q[query_tag];
  assign query_exception = exc_q[query_tag];

endmodule

`default_nettype wire

// File: verification/completion_chk.sv
`timescale 1ns/100ps
`default_nettype none

module completion_chk (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire core_pkg::lane_mask_t complete_in,
  input  wire core_pkg::lane_mask_t broadcast,
  input  wire logic                 exception2,
  input  wire logic                 exception3
);

  int fail_count = 0;   // summed into the testbench result

  a_reset_clear: assert property (@(posedge clock) reset |=> (broadcast == '0))
  else
  begin
    fail_count++;
    $error("broadcast not cleared in the cycle after reset");
  end

  a_mul_no_exc: assert property (@(posedge clock) disable iff (reset)
                                 (!exception2 && !exception3))
  else
  begin
    fail_count++;
    $error("multiplier lane broadcast an exception");
  end

  a_strobe_follow: assert property (@(posedge clock)
                                    !reset |=> (broadcast == $past(complete_in)))
  else
  begin
    fail_count++;
    $error("broadcast bits do not match the previous cycle's strobes");
  end

endmodule

bind cdb completion_chk u_completion_chk (
  .clock       (clock),
  .reset       (reset),
  .complete_in ({mem_complete1, mem_complete0, mul_complete1,
                 mul_complete0, sim_complete1, sim_complete0}),
  .broadcast   (broadcast),
  .exception2  (exception2),
  .exception3  (exception3)
);

`default_nettype wire

// File: verification/completion_tb.sv
`timescale 1ns/100ps
`default_nettype none

module completion_tb;

  typedef struct packed {
    logic                        ren_v;
    core_pkg::areg_t             ren_ar;
    core_pkg::preg_t             ren_pr;
    core_pkg::lane_mask_t        strobe;
    core_pkg::preg_t [5:0]       pr;
    core_pkg::areg_t [5:0]       ar;
    logic [5:0]                  exc;
    core_pkg::addr_t [1:0]       pc;
    core_pkg::addr_t [1:0]       target;
    logic [1:0]                  taken;
    logic [1:0]                  cond;
    logic [1:0]                  uncond;
    core_pkg::areg_t             look_ar;
    core_pkg::preg_t             query;
  } row_t;

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 sim_complete0, sim_exception0, sim_actual_taken0;
  logic                 sim_cond_branch0, sim_uncond_branch0;
  logic                 sim_complete1, sim_exception1, sim_actual_taken1;
  logic                 sim_cond_branch1, sim_uncond_branch1;
  core_pkg::preg_t      sim_pr_idx0, sim_pr_idx1, mul_pr_idx0, mul_pr_idx1;
  core_pkg::preg_t      mem_pr_idx0, mem_pr_idx1, rename_pr, query_tag, lookup_pr;
  core_pkg::areg_t      sim_ar_idx0, sim_ar_idx1, mul_ar_idx0, mul_ar_idx1;
  core_pkg::areg_t      mem_ar_idx0, mem_ar_idx1, rename_ar, lookup_ar;
  core_pkg::addr_t      sim_pc0, sim_pc1, sim_actual_addr0, sim_actual_addr1;
  core_pkg::addr_t      redirect_pc, redirect_target;
  logic                 mul_complete0, mul_complete1;
  logic                 mem_complete0, mem_exception0, mem_complete1, mem_exception1;
  logic                 rename_valid, lookup_ready, query_done, query_exception;
  logic                 redirect_valid;

  row_t                 rows [$];
  row_t                 cur;                  // row under construction
  logic                 table_built = 1'b0;
  int                   seed = 11450;
  int                   checks = 0;
  int                   errors = 0;

  // reference model, state as seen after the last edge
  core_pkg::preg_t      model_map [32];
  logic                 model_ready [32];
  logic                 model_done [128];
  logic                 model_exc [128];
  row_t                 bus_stage;            // lanes currently on the bus
  logic                 model_rd_valid;
  core_pkg::addr_t      model_rd_pc;
  core_pkg::addr_t      model_rd_target;

  completion_top u_completion_top (.*);

  always #10 clock = ~clock;

  // ----------------------------------------------------------------------
  // row construction
  // ----------------------------------------------------------------------
  task automatic new_row();
    cur.ren_v  = 1'b0;
    cur.ren_ar = core_pkg::areg_t'($random(seed));
    cur.ren_pr = core_pkg::preg_t'($random(seed));
    cur.strobe = '0;
    for (int k = 0; k < 6; k++)
    begin
      cur.pr[k]  = core_pkg::preg_t'($random(seed));
      cur.ar[k]  = core_pkg::areg_t'($random(seed));
      cur.exc[k] = 1'($random(seed));
    end
    for (int k = 0; k < 2; k++)
    begin
      cur.pc[k]     = {$random(seed), $random(seed)};
      cur.target[k] = {$random(seed), $random(seed)};
      cur.taken[k]  = 1'($random(seed));
      cur.cond[k]   = 1'($random(seed));
      cur.uncond[k] = 1'($random(seed));
    end
  endtask

  task automatic rename_reg(input core_pkg::areg_t ar, input core_pkg::preg_t pr);
    cur.ren_v  = 1'b1;
    cur.ren_ar = ar;
    cur.ren_pr = pr;
  endtask

  task automatic complete(input int lane, input core_pkg::preg_t pr,
                          input core_pkg::areg_t ar, input logic exc);
    cur.strobe[lane] = 1'b1;
    cur.pr[lane]     = pr;
    cur.ar[lane]     = ar;
    cur.exc[lane]    = exc;
    if (lane < 2)
    begin
      cur.cond[lane]   = 1'b0;   // plain alu op
      cur.uncond[lane] = 1'b0;
    end
  endtask

  task automatic branch(input int lane, input logic cond, input logic uncond,
                        input logic taken, input core_pkg::addr_t target);
    cur.cond[lane]   = cond;
    cur.uncond[lane] = uncond;
    cur.taken[lane]  = taken;
    cur.target[lane] = target;
  endtask

  task automatic watch(input core_pkg::areg_t ar, input core_pkg::preg_t tag);
    cur.look_ar = ar;   // sticky over the rows that follow
    cur.query   = tag;
  endtask

  task automatic push_row();
    rows.push_back(cur);
  endtask

  task automatic idle_rows(input int count);
    repeat (count)
    begin
      new_row();
      push_row();
    end
  endtask

  task automatic build_table();
    cur = '0;
    for (int i = 0; i < 128; i++)
    begin
      new_row();
      watch(core_pkg::areg_t'(i), core_pkg::preg_t'(i));
      push_row();
    end
    // one completion per lane
    for (int k = 0; k < 6; k++)
    begin
      new_row();
      rename_reg(core_pkg::areg_t'(k + 1), core_pkg::preg_t'(40 + k));
      watch(core_pkg::areg_t'(k + 1), core_pkg::preg_t'(40 + k));
      push_row();
      new_row();
      complete(k, core_pkg::preg_t'(40 + k), core_pkg::areg_t'(k + 1), 1'b0);
      push_row();
      idle_rows(3);
    end
    // stale tag on the bus
    new_row();
    rename_reg(8, 60);
    watch(8, 60);
    push_row();
    new_row();
    rename_reg(8, 61);
    push_row();
    new_row();
    complete(4, 60, 8, 1'b0);
    push_row();
    idle_rows(3);
    new_row();
    complete(3, 61, 8, 1'b0);
    watch(8, 61);
    push_row();
    idle_rows(3);
    // exceptions per tag, multiplier flag dropped
    new_row();
    rename_reg(9, 70);
    push_row();
    new_row();
    rename_reg(10, 71);
    push_row();
    new_row();
    rename_reg(11, 72);
    push_row();
    new_row();
    complete(0, 70, 9, 1'b1);
    complete(5, 71, 10, 1'b1);
    complete(2, 72, 11, 1'b1);
    complete(1, 73, 13, 1'b1);
    complete(4, 74, 14, 1'b0);
    push_row();
    for (int t = 70; t < 75; t++)
    begin
      new_row();
      watch(core_pkg::areg_t'(t - 61), core_pkg::preg_t'(t));
      push_row();
    end
    new_row();
    rename_reg(15, 70);   // reallocation clears the old exception
    watch(15, 70);
    push_row();
    idle_rows(2);
    // ----------------------------------------------------------------------
    // branches, not-taken prediction
    // ----------------------------------------------------------------------
    new_row();
    complete(0, 90, 16, 1'b0);
    branch(0, 1'b1, 1'b0, 1'b1, 64'h0000_0000_8000_1000);
    push_row();
    new_row();
    complete(1, 91, 17, 1'b0);
    branch(1, 1'b0, 1'b1, 1'b0, 64'h0000_0000_8000_2000);
    push_row();
    new_row();
    complete(0, 92, 18, 1'b0);
    branch(0, 1'b1, 1'b0, 1'b0, 64'h0000_0000_8000_3000);
    push_row();
    new_row();
    complete(0, 93, 19, 1'b0);
    complete(1, 94, 20, 1'b0);
    branch(0, 1'b0, 1'b1, 1'b0, 64'h0000_0000_8000_4000);
    branch(1, 1'b1, 1'b0, 1'b1, 64'h0000_0000_8000_5000);
    push_row();
    new_row();
    complete(0, 95, 21, 1'b0);
    complete(1, 96, 22, 1'b0);
    branch(0, 1'b1, 1'b0, 1'b0, 64'h0000_0000_8000_6000);
    branch(1, 1'b1, 1'b0, 1'b1, 64'h0000_0000_8000_7000);
    push_row();
    idle_rows(3);
    // rename while the old tag is on the bus
    new_row();
    rename_reg(12, 80);
    watch(12, 81);
    push_row();
    new_row();
    complete(5, 80, 12, 1'b0);
    push_row();
    new_row();
    rename_reg(12, 81);
    push_row();
    idle_rows(3);
    for (int i = 0; i < 40; i++)
    begin
      new_row();
      cur.ren_v   = 1'($random(seed));
      cur.strobe  = core_pkg::lane_mask_t'($random(seed));
      cur.look_ar = core_pkg::areg_t'($random(seed));
      cur.query   = core_pkg::preg_t'($random(seed));
      push_row();
    end
    idle_rows(3);
  endtask

  // ----------------------------------------------------------------------
  // reference model and checks
  // ----------------------------------------------------------------------
  task automatic reset_model();
    for (int i = 0; i < 32; i++)
    begin
      model_map[i]   = core_pkg::preg_t'(i);
      model_ready[i] = 1'b1;
    end
    for (int i = 0; i < 128; i++)
    begin
      model_done[i] = 1'b1;
      model_exc[i]  = 1'b0;
    end
    bus_stage      = '0;
    model_rd_valid = 1'b0;
  endtask

  // advance the model across one rising edge with row r on the inputs
  task automatic step_model(input row_t r);
    logic mp0;
    logic mp1;
    mp0 = bus_stage.strobe[0] &&
          ((bus_stage.cond[0] && bus_stage.taken[0]) || bus_stage.uncond[0]);
    mp1 = bus_stage.strobe[1] &&
          ((bus_stage.cond[1] && bus_stage.taken[1]) || bus_stage.uncond[1]);
    model_rd_valid = mp0 || mp1;
    if (mp0 || mp1)
    begin
      model_rd_pc     = mp0 ? bus_stage.pc[0] : bus_stage.pc[1];
      model_rd_target = mp0 ? bus_stage.target[0] : bus_stage.target[1];
    end
    for (int k = 0; k < 6; k++)
    begin
      if (bus_stage.strobe[k])
      begin
        if (model_map[bus_stage.ar[k]] == bus_stage.pr[k])
          model_ready[bus_stage.ar[k]] = 1'b1;
        model_done[bus_stage.pr[k]] = 1'b1;
        model_exc[bus_stage.pr[k]]  = (k == 2 || k == 3) ? 1'b0 : bus_stage.exc[k];
      end
    end
    if (r.ren_v)
    begin
      model_map[r.ren_ar]   = r.ren_pr;
      model_ready[r.ren_ar] = 1'b0;
      model_done[r.ren_pr]  = 1'b0;
      model_exc[r.ren_pr]   = 1'b0;
    end
    bus_stage = r;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_outputs(input row_t r);
    check_value("lookup_pr", 64'(lookup_pr), 64'(model_map[r.look_ar]));
    check_value("lookup_ready", 64'(lookup_ready), 64'(model_ready[r.look_ar]));
    check_value("query_done", 64'(query_done), 64'(model_done[r.query]));
    check_value("query_exception", 64'(query_exception), 64'(model_exc[r.query]));
    check_value("redirect_valid", 64'(redirect_valid), 64'(model_rd_valid));
    if (model_rd_valid)
    begin
      check_value("redirect_pc", redirect_pc, model_rd_pc);
      check_value("redirect_target", redirect_target, model_rd_target);
    end
  endtask

  task automatic drive_inputs(input row_t r);
    rename_valid       = r.ren_v;
    rename_ar          = r.ren_ar;
    rename_pr          = r.ren_pr;
    lookup_ar          = r.look_ar;
    query_tag          = r.query;
    sim_complete0      = r.strobe[0];
    sim_pr_idx0        = r.pr[0];
    sim_ar_idx0        = r.ar[0];
    sim_exception0     = r.exc[0];
    sim_pc0            = r.pc[0];
    sim_actual_addr0   = r.target[0];
    sim_actual_taken0  = r.taken[0];
    sim_cond_branch0   = r.cond[0];
    sim_uncond_branch0 = r.uncond[0];
    sim_complete1      = r.strobe[1];
    sim_pr_idx1        = r.pr[1];
    sim_ar_idx1        = r.ar[1];
    sim_exception1     = r.exc[1];
    sim_pc1            = r.pc[1];
    sim_actual_addr1   = r.target[1];
    sim_actual_taken1  = r.taken[1];
    sim_cond_branch1   = r.cond[1];
    sim_uncond_branch1 = r.uncond[1];
    mul_complete0      = r.strobe[2];
    mul_pr_idx0        = r.pr[2];
    mul_ar_idx0        = r.ar[2];
    mul_complete1      = r.strobe[3];
    mul_pr_idx1        = r.pr[3];
    mul_ar_idx1        = r.ar[3];
    mem_complete0      = r.strobe[4];
    mem_pr_idx0        = r.pr[4];
    mem_ar_idx0        = r.ar[4];
    mem_exception0     = r.exc[4];
    mem_complete1      = r.strobe[5];
    mem_pr_idx1        = r.pr[5];
    mem_ar_idx1        = r.ar[5];
    mem_exception1     = r.exc[5];
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    row_t reset_row;
    int   chk_fails;
    reset_row        = '0;
    reset_row.ren_v  = 1'b1;     // busy inputs that reset must mask
    reset_row.strobe = '1;
    reset_row.uncond = 2'b11;
    reset = 1'b1;
    drive_inputs(reset_row);
    build_table();
    table_built = 1'b1;
    reset_model();
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;
    foreach (rows[i])
    begin
      drive_inputs(rows[i]);
      @(negedge clock);                       // outputs settled
      check_outputs(rows[i]);
      step_model(rows[i]);
      @(posedge clock);
      #2;
    end
    chk_fails = u_completion_top.u_cdb.u_completion_chk.fail_count;
    $display("rows: %0d, checks: %0d, value errors: %0d, assertion errors: %0d",
             rows.size(), checks, errors, chk_fails);
    if (errors == 0 && chk_fails == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    wait (table_built);
    #(rows.size() * 20 + 300);                // rows plus reset and margin
    $display("watchdog expired before all table rows were applied");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
